//--- gps_types_pkg.sv
////////////////////////////////////////
// Field types of the per-channel state word
// kept in the shared state memory, and the
// channel index. Import where a module uses
// the types in its body.
////////////////////////////////////////
`default_nettype none

package gps_types_pkg;

   // PRN number, 1 to 32
   typedef logic [5:0] prn_t;
   // Signed offset on the nominal code rate
   typedef logic signed [15:0] dphi_t;
   // Code-clock phase accumulator
   typedef logic [15:0] ca_acc_t;
   // G1 or G2 register, numbered as in the ICD
   typedef logic [10:1] lfsr_t;
   // Chip index within one code epoch
   typedef logic [9:0] chip_cnt_t;
   // Channel index, room for four channels
   typedef logic [1:0] chan_t;

   // Width of one packed state word
   function automatic int state_width(int hist_width);
      return $bits(prn_t) + $bits(dphi_t) + $bits(ca_acc_t) + 1 +
             2 * $bits(lfsr_t) + $bits(chip_cnt_t) + 2 * hist_width;
   endfunction

endpackage

`default_nettype wire

//--- ca_code_pkg.sv
////////////////////////////////////////
// GPS C/A code constants. Code length,
// nominal code-clock increment and the G2
// tap selection per PRN (ICD table).
////////////////////////////////////////
`default_nettype none

package ca_code_pkg;

   // Chips per code epoch
   localparam int ca_code_len = 1023;

   // Quarter turn of the accumulator per step
   // One chip every four channel steps at zero offset
   localparam logic [15:0] ca_rate_inc = 16'd16384;

   // G2 taps per PRN, high nibble is tap A, low nibble tap B
   localparam logic [7:0] g2_taps [1:32] = '{
      8'h26, 8'h37, 8'h48, 8'h59, 8'h19, 8'h2a, 8'h18, 8'h29,
      8'h3a, 8'h23, 8'h34, 8'h56, 8'h67, 8'h78, 8'h89, 8'h9a,
      8'h14, 8'h25, 8'h36, 8'h47, 8'h58, 8'h69, 8'h13, 8'h46,
      8'h57, 8'h68, 8'h79, 8'h8a, 8'h16, 8'h27, 8'h38, 8'h49
   };

   // First G2 tap position for a PRN
   function automatic logic [3:0] g2_tap_a(gps_types_pkg::prn_t prn);
      // Unconfigured PRN falls back to taps 1 and 2
      if (prn >= 6'd1 && prn <= 6'd32)
         return g2_taps[prn][7:4];
      return 4'd1;
   endfunction

   // Second G2 tap position for a PRN
   function automatic logic [3:0] g2_tap_b(gps_types_pkg::prn_t prn);
      if (prn >= 6'd1 && prn <= 6'd32)
         return g2_taps[prn][3:0];
      return 4'd2;
   endfunction

endpackage

`default_nettype wire

//--- ca_generator_sw.sv
////////////////////////////////////////
// One step of the G1/G2 C/A generator.
// Pure combinational, the registers live
// outside and are passed in and out, so a
// single instance serves every channel.
////////////////////////////////////////
`default_nettype none

module ca_generator_sw (
   input  wire logic                     enable,
   input  wire gps_types_pkg::prn_t      prn,
   input  wire gps_types_pkg::lfsr_t     g1_in,
   input  wire gps_types_pkg::lfsr_t     g2_in,
   input  wire gps_types_pkg::chip_cnt_t chip_cnt_in,
   output gps_types_pkg::lfsr_t          g1_out,
   output gps_types_pkg::lfsr_t          g2_out,
   output gps_types_pkg::chip_cnt_t      chip_cnt_out,
   output logic                          chip,
   output logic                          epoch
);
   import gps_types_pkg::*;
   import ca_code_pkg::*;

   logic [3:0] tap_a;
   logic [3:0] tap_b;
   logic       g1_fb;
   logic       g2_fb;
   logic       wrap;

   // PRN-selected G2 phase taps
   assign tap_a = g2_tap_a(prn);
   assign tap_b = g2_tap_b(prn);

   // Current chip from the present register contents
   assign chip = g1_in[10] ^ g2_in[tap_a] ^ g2_in[tap_b];

   // G1 is 1 + x^3 + x^10
   assign g1_fb = g1_in[3] ^ g1_in[10];
   // G2 is 1 + x^2 + x^3 + x^6 + x^8 + x^9 + x^10
   assign g2_fb = g2_in[2] ^ g2_in[3] ^ g2_in[6] ^ g2_in[8] ^ g2_in[9] ^ g2_in[10];

   // Last chip of the epoch
   assign wrap = chip_cnt_in == chip_cnt_t'(ca_code_len - 1);

   always_comb begin
      g1_out       = g1_in;
      g2_out       = g2_in;
      chip_cnt_out = chip_cnt_in;
      epoch        = 1'b0;
      if (enable) begin
         if (wrap) begin
            // Epoch boundary, restart both registers
            g1_out       = '1;
            g2_out       = '1;
            chip_cnt_out = '0;
            epoch        = 1'b1;
         end else begin
            g1_out       = {g1_in[9:1], g1_fb};
            g2_out       = {g2_in[9:1], g2_fb};
            chip_cnt_out = chip_cnt_in + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- ca_upsampler_sw.sv
////////////////////////////////////////
// Switching C/A upsampler. Takes one
// channel's state on step, and one cycle
// later presents the early, prompt and late
// chips, the chip strobe and the next state.
////////////////////////////////////////
`default_nettype none

module ca_upsampler_sw #(
   parameter int hist_width = 2
) (
   input  wire logic                     clk,
   input  wire logic                     rst_n,
   input  wire logic                     step,
   // Channel configuration
   input  wire gps_types_pkg::prn_t      prn,
   input  wire gps_types_pkg::dphi_t     dphi,
   // Upsampler and generator state in
   input  wire gps_types_pkg::ca_acc_t   acc_in,
   input  wire logic                     clk_hist_in,
   input  wire gps_types_pkg::lfsr_t     g1_in,
   input  wire gps_types_pkg::lfsr_t     g2_in,
   input  wire gps_types_pkg::chip_cnt_t chip_cnt_in,
   input  wire logic [hist_width-1:0]    prompt_hist_in,
   input  wire logic [hist_width-1:0]    late_hist_in,
   // Next state out
   output gps_types_pkg::ca_acc_t        acc_out,
   output logic                          clk_hist_out,
   output gps_types_pkg::lfsr_t          g1_out,
   output gps_types_pkg::lfsr_t          g2_out,
   output gps_types_pkg::chip_cnt_t      chip_cnt_out,
   output logic [hist_width-1:0]         prompt_hist_out,
   output logic [hist_width-1:0]         late_hist_out,
   // Code outputs
   output logic                          early,
   output logic                          prompt,
   output logic                          late,
   output logic                          chip_stb,
   output logic                          epoch
);
   import gps_types_pkg::*;
   import ca_code_pkg::*;

   typedef logic [hist_width-1:0] chip_hist_t;

   localparam int acc_msb = $bits(ca_acc_t) - 1;

   // Alignment stage, one copy of every input
   prn_t       prn_q;
   dphi_t      dphi_q;
   ca_acc_t    acc_q;
   logic       clk_hist_q;
   lfsr_t      g1_q;
   lfsr_t      g2_q;
   chip_cnt_t  chip_cnt_q;
   chip_hist_t prompt_q;
   chip_hist_t late_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         prn_q      <= '0;
         dphi_q     <= '0;
         acc_q      <= '0;
         clk_hist_q <= 1'b0;
         g1_q       <= '0;
         g2_q       <= '0;
         chip_cnt_q <= '0;
         prompt_q   <= '0;
         late_q     <= '0;
      end else if (step) begin
         prn_q      <= prn;
         dphi_q     <= dphi;
         acc_q      <= acc_in;
         clk_hist_q <= clk_hist_in;
         g1_q       <= g1_in;
         g2_q       <= g2_in;
         chip_cnt_q <= chip_cnt_in;
         prompt_q   <= prompt_hist_in;
         late_q     <= late_hist_in;
      end
   end

   // Code clock, nominal increment plus the rate offset
   assign acc_out = acc_q + ca_rate_inc + ca_acc_t'(dphi_q);

   // Inverted accumulator MSB is the code clock
   assign clk_hist_out = ~acc_out[acc_msb];
   // Rising edge against the previous step of this channel
   assign chip_stb = clk_hist_out & ~clk_hist_q;

   // Generator advances once per chip strobe
   ca_generator_sw u_gen (
      .enable       (chip_stb),
      .prn          (prn_q),
      .g1_in        (g1_q),
      .g2_in        (g2_q),
      .chip_cnt_in  (chip_cnt_q),
      .g1_out       (g1_out),
      .g2_out       (g2_out),
      .chip_cnt_out (chip_cnt_out),
      .chip         (early),
      .epoch        (epoch)
   );

   // Prompt trails early by hist_width steps
   assign prompt_hist_out = {prompt_q[hist_width-2:0], early};
   assign prompt          = prompt_q[hist_width-1];

   // Late trails prompt by the same amount
   assign late_hist_out = {late_q[hist_width-2:0], prompt};
   assign late          = late_q[hist_width-1];

endmodule

`default_nettype wire

//--- state_ram.sv
////////////////////////////////////////
// Channel state memory. One packed word
// per channel, single port, read data
// registered one cycle after the address.
////////////////////////////////////////
`default_nettype none

module state_ram #(
   parameter int  num_chan   = 4,
   parameter int  hist_width = 2,
   localparam int state_w    = gps_types_pkg::state_width(hist_width)
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 we,
   input  wire gps_types_pkg::chan_t addr,
   input  wire logic [state_w-1:0]   wdata,
   output logic [state_w-1:0]        rdata
);

   logic [state_w-1:0] mem [num_chan];

   // Read before write on the same address
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // Start every channel from a known word
         for (int i = 0; i < num_chan; i++) begin
            mem[i] <= '0;
         end
         rdata <= '0;
      end else begin
         if (we) begin
            mem[addr] <= wdata;
         end
         rdata <= mem[addr];
      end
   end

endmodule

`default_nettype wire

//--- state_arbiter.sv
////////////////////////////////////////
// Arbiter in front of the state memory.
// Host configuration writes win over the
// channel sequencer, and only the granted
// peer reaches the memory port.
////////////////////////////////////////
`default_nettype none

module state_arbiter #(
   parameter int  hist_width = 2,
   localparam int state_w    = gps_types_pkg::state_width(hist_width)
) (
   // Host port, always a write
   input  wire logic                 host_req,
   input  wire gps_types_pkg::chan_t host_addr,
   input  wire logic [state_w-1:0]   host_wdata,
   // Sequencer port
   input  wire logic                 seq_req,
   input  wire logic                 seq_we,
   input  wire gps_types_pkg::chan_t seq_addr,
   input  wire logic [state_w-1:0]   seq_wdata,
   // Grants
   output logic                      host_gnt,
   output logic                      seq_gnt,
   // Memory port
   output logic                      mem_we,
   output gps_types_pkg::chan_t      mem_addr,
   output logic [state_w-1:0]        mem_wdata
);

   // Fixed priority, host first
   assign host_gnt = host_req;
   assign seq_gnt  = seq_req & ~host_req;

   // Memory request of the granted peer
   always_comb begin
      if (host_gnt) begin
         mem_we    = 1'b1;
         mem_addr  = host_addr;
         mem_wdata = host_wdata;
      end else begin
         // Idle cycles still present the sequencer address
         mem_we    = seq_gnt & seq_we;
         mem_addr  = seq_addr;
         mem_wdata = seq_wdata;
      end
   end

endmodule

`default_nettype wire

//--- channel_sequencer.sv
////////////////////////////////////////
// Round-robin channel walker. Per slot it
// reads a channel's state, steps the shared
// upsampler and writes the new state back,
// dropping the write-back when the host has
// rewritten the same channel meanwhile.
////////////////////////////////////////
`default_nettype none

module channel_sequencer #(
   parameter int  num_chan   = 4,
   parameter int  hist_width = 2,
   localparam int state_w    = gps_types_pkg::state_width(hist_width)
) (
   input  wire logic                     clk,
   input  wire logic                     rst_n,
   // Memory access through the arbiter
   input  wire logic                     seq_gnt,
   input  wire logic [state_w-1:0]       rdata,
   output logic                          seq_req,
   output logic                          seq_we,
   output gps_types_pkg::chan_t          seq_addr,
   output logic [state_w-1:0]            seq_wdata,
   // Host write seen this cycle
   input  wire logic                     host_hit,
   input  wire gps_types_pkg::chan_t     host_chan,
   // State toward the upsampler
   output logic                          step,
   output gps_types_pkg::prn_t           prn,
   output gps_types_pkg::dphi_t          dphi,
   output gps_types_pkg::ca_acc_t        acc,
   output logic                          clk_hist,
   output gps_types_pkg::lfsr_t          g1,
   output gps_types_pkg::lfsr_t          g2,
   output gps_types_pkg::chip_cnt_t      chip_cnt,
   output logic [hist_width-1:0]         prompt_hist,
   output logic [hist_width-1:0]         late_hist,
   // Next state from the upsampler
   input  wire gps_types_pkg::ca_acc_t   acc_nxt,
   input  wire logic                     clk_hist_nxt,
   input  wire gps_types_pkg::lfsr_t     g1_nxt,
   input  wire gps_types_pkg::lfsr_t     g2_nxt,
   input  wire gps_types_pkg::chip_cnt_t chip_cnt_nxt,
   input  wire logic [hist_width-1:0]    prompt_hist_nxt,
   input  wire logic [hist_width-1:0]    late_hist_nxt,
   // Slot done
   output logic                          smp_valid,
   output gps_types_pkg::chan_t          smp_chan
);
   import gps_types_pkg::*;

   typedef enum logic [1:0] {s_read, s_wait, s_step, s_write} seq_state_t;

   seq_state_t         state;
   chan_t              chan_q;
   chan_t              chan_nxt;
   logic               drop_q;
   logic               hit_now;
   logic [state_w-1:0] st_q;

   // Host rewrite of the channel in flight
   assign hit_now = host_hit && (host_chan == chan_q);

   assign chan_nxt = (chan_q == chan_t'(num_chan - 1)) ? '0 : chan_q + 1'b1;

   assign seq_addr = chan_q;
   assign smp_chan = chan_q;

   // Unpack the state word read for this slot
   assign {prn, dphi, acc, clk_hist, g1, g2, chip_cnt, prompt_hist, late_hist} = st_q;

   // Configuration stays, dynamic fields come from the upsampler
   assign seq_wdata = {prn, dphi, acc_nxt, clk_hist_nxt, g1_nxt, g2_nxt,
                       chip_cnt_nxt, prompt_hist_nxt, late_hist_nxt};

   always_comb begin
      seq_req   = 1'b0;
      seq_we    = 1'b0;
      step      = 1'b0;
      smp_valid = 1'b0;
      case (state)
         s_read: seq_req = 1'b1;
         s_step: step = 1'b1;
         s_write: begin
            // No write-back request once the slot is dropped
            seq_req   = ~drop_q;
            seq_we    = ~drop_q;
            smp_valid = ~drop_q & seq_gnt;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= s_read;
         chan_q <= '0;
         drop_q <= 1'b0;
      end else begin
         case (state)
            s_read: begin
               if (seq_gnt) begin
                  state <= s_wait;
               end
            end
            s_wait: begin
               drop_q <= hit_now;
               state  <= s_step;
            end
            s_step: begin
               drop_q <= drop_q | hit_now;
               state  <= s_write;
            end
            s_write: begin
               // Done on grant, or skipped after a host rewrite
               if (drop_q || hit_now || seq_gnt) begin
                  chan_q <= chan_nxt;
                  drop_q <= 1'b0;
                  state  <= s_read;
               end
            end
            default: state <= s_read;
         endcase
      end
   end

   // Read data is valid in the cycle after the read grant
   always_ff @(posedge clk) begin
      if (state == s_wait) begin
         st_q <= rdata;
      end
   end

endmodule

`default_nettype wire

//--- ca_channel_top.sv
////////////////////////////////////////
// Time-multiplexed C/A code channel.
// The host configures channels by strobe,
// the sequencer steps them in turn and each
// finished slot is marked by smp_valid.
////////////////////////////////////////
`default_nettype none

module ca_channel_top #(
   parameter int num_chan   = 4,
   parameter int hist_width = 2
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   // Host configuration strobe
   input  wire logic                 cfg_we,
   input  wire gps_types_pkg::chan_t cfg_chan,
   input  wire gps_types_pkg::prn_t  cfg_prn,
   input  wire gps_types_pkg::dphi_t cfg_dphi,
   // Per-slot code outputs
   output logic                      smp_valid,
   output gps_types_pkg::chan_t      smp_chan,
   output logic                      early,
   output logic                      prompt,
   output logic                      late,
   output logic                      chip_stb,
   output logic                      epoch
);
   import gps_types_pkg::*;

   localparam int state_w = state_width(hist_width);

   typedef logic [hist_width-1:0] chip_hist_t;

   logic               host_gnt;
   logic               seq_gnt;
   logic               seq_req;
   logic               seq_we;
   chan_t              seq_addr;
   logic [state_w-1:0] seq_wdata;
   logic               mem_we;
   chan_t              mem_addr;
   logic [state_w-1:0] mem_wdata;
   logic [state_w-1:0] rdata;
   logic [state_w-1:0] init_word;

   // Sequencer to upsampler
   logic       step;
   prn_t       prn;
   dphi_t      dphi;
   ca_acc_t    acc;
   logic       clk_hist;
   lfsr_t      g1;
   lfsr_t      g2;
   chip_cnt_t  chip_cnt;
   chip_hist_t prompt_hist;
   chip_hist_t late_hist;

   // Upsampler back to sequencer
   ca_acc_t    acc_nxt;
   logic       clk_hist_nxt;
   lfsr_t      g1_nxt;
   lfsr_t      g2_nxt;
   chip_cnt_t  chip_cnt_nxt;
   chip_hist_t prompt_hist_nxt;
   chip_hist_t late_hist_nxt;
   logic       up_chip_stb;
   logic       up_epoch;

   // Fresh channel, registers all ones and strobe history set
   assign init_word = {cfg_prn, cfg_dphi, ca_acc_t'(0), 1'b1, lfsr_t'('1), lfsr_t'('1),
                       chip_cnt_t'(0), chip_hist_t'(0), chip_hist_t'(0)};

   // Strobes only count at the end of a written slot
   assign chip_stb = smp_valid & up_chip_stb;
   assign epoch    = smp_valid & up_epoch;

   state_arbiter #(.hist_width(hist_width)) u_arb (
      .host_req   (cfg_we),
      .host_addr  (cfg_chan),
      .host_wdata (init_word),
      .seq_req    (seq_req),
      .seq_we     (seq_we),
      .seq_addr   (seq_addr),
      .seq_wdata  (seq_wdata),
      .host_gnt   (host_gnt),
      .seq_gnt    (seq_gnt),
      .mem_we     (mem_we),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata)
   );

   state_ram #(.num_chan(num_chan), .hist_width(hist_width)) u_ram (
      .clk   (clk),
      .rst_n (rst_n),
      .we    (mem_we),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .rdata (rdata)
   );

   channel_sequencer #(.num_chan(num_chan), .hist_width(hist_width)) u_seq (
      .clk             (clk),
      .rst_n           (rst_n),
      .seq_gnt         (seq_gnt),
      .rdata           (rdata),
      .seq_req         (seq_req),
      .seq_we          (seq_we),
      .seq_addr        (seq_addr),
      .seq_wdata       (seq_wdata),
      .host_hit        (host_gnt),
      .host_chan       (cfg_chan),
      .step            (step),
      .prn             (prn),
      .dphi            (dphi),
      .acc             (acc),
      .clk_hist        (clk_hist),
      .g1              (g1),
      .g2              (g2),
      .chip_cnt        (chip_cnt),
      .prompt_hist     (prompt_hist),
      .late_hist       (late_hist),
      .acc_nxt         (acc_nxt),
      .clk_hist_nxt    (clk_hist_nxt),
      .g1_nxt          (g1_nxt),
      .g2_nxt          (g2_nxt),
      .chip_cnt_nxt    (chip_cnt_nxt),
      .prompt_hist_nxt (prompt_hist_nxt),
      .late_hist_nxt   (late_hist_nxt),
      .smp_valid       (smp_valid),
      .smp_chan        (smp_chan)
   );

   ca_upsampler_sw #(.hist_width(hist_width)) u_up (
      .clk             (clk),
      .rst_n           (rst_n),
      .step            (step),
      .prn             (prn),
      .dphi            (dphi),
      .acc_in          (acc),
      .clk_hist_in     (clk_hist),
      .g1_in           (g1),
      .g2_in           (g2),
      .chip_cnt_in     (chip_cnt),
      .prompt_hist_in  (prompt_hist),
      .late_hist_in    (late_hist),
      .acc_out         (acc_nxt),
      .clk_hist_out    (clk_hist_nxt),
      .g1_out          (g1_nxt),
      .g2_out          (g2_nxt),
      .chip_cnt_out    (chip_cnt_nxt),
      .prompt_hist_out (prompt_hist_nxt),
      .late_hist_out   (late_hist_nxt),
      .early           (early),
      .prompt          (prompt),
      .late            (late),
      .chip_stb        (up_chip_stb),
      .epoch           (up_epoch)
   );

endmodule

`default_nettype wire

//--- ca_channel_asserts.sv
////////////////////////////////////////
// Concurrent checks on the state memory
// arbitration and the slot pulse. Bound
// into the channel top level.
////////////////////////////////////////
`default_nettype none

module ca_channel_asserts (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic host_gnt,
   input wire logic seq_gnt,
   input wire logic seq_req,
   input wire logic smp_valid
);

   // Failures seen, read by the testbench at the end
   int fail_cnt = 0;

   // One grant per cycle at most
   gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      !(host_gnt && seq_gnt))
   else begin
      $error("host and sequencer granted in the same cycle");
      fail_cnt++;
   end

   // Sequencer keeps asking while held off
   req_held: assert property (@(posedge clk) disable iff (!rst_n)
      (seq_req && !seq_gnt) |=> seq_req)
   else begin
      $error("sequencer dropped its request before grant");
      fail_cnt++;
   end

   // End of slot is a single-cycle pulse
   valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      smp_valid |=> !smp_valid)
   else begin
      $error("smp_valid longer than one cycle");
      fail_cnt++;
   end

endmodule

bind ca_channel_top ca_channel_asserts u_chk (
   .clk       (clk),
   .rst_n     (rst_n),
   .host_gnt  (host_gnt),
   .seq_gnt   (seq_gnt),
   .seq_req   (seq_req),
   .smp_valid (smp_valid)
);

`default_nettype wire

//--- ca_channel_tb.sv
////////////////////////////////////////
// Testbench for the C/A channel top.
// Reads channel setup and expected chips
// from ca_stim.txt, rewrites channel 3 at
// random for contention and checks every
// finished slot against its own channel model.
////////////////////////////////////////
`default_nettype none

module ca_channel_tb;
   import gps_types_pkg::*;

   localparam int num_chan     = 4;
   localparam int hist_width   = 2;
   localparam int stim_words   = 80;
   localparam int max_cfg      = 8;
   localparam int max_cycles   = 200000;
   localparam int rewrite_from = 32;
   localparam int code_len     = ca_code_pkg::ca_code_len;
   localparam int run_chips    = code_len + 10;

   logic  clk;
   logic  rst_n;
   logic  cfg_we;
   chan_t cfg_chan;
   prn_t  cfg_prn;
   dphi_t cfg_dphi;
   logic  smp_valid;
   chan_t smp_chan;
   logic  early;
   logic  prompt;
   logic  late;
   logic  chip_stb;
   logic  epoch;

   logic [31:0] stim [stim_words];
   logic [31:0] lcg_state;

   // Setup commands from the stim file
   int    n_cfg;
   int    cfg_cycle [max_cfg];
   chan_t cfg_chan_tab [max_cfg];
   prn_t  cfg_prn_tab [max_cfg];
   dphi_t cfg_dphi_tab [max_cfg];

   // Channel model
   logic                  cfg_seen [num_chan];
   logic                  host_hit [num_chan];
   dphi_t                 chan_dphi [num_chan];
   prn_t                  chan_prn [num_chan];
   logic [9:0]            chan_word [num_chan];
   int                    step_cnt [num_chan];
   int                    stb_cnt [num_chan];
   int                    stb64_cnt [num_chan];
   logic [hist_width-1:0] early_hist [num_chan];
   logic [hist_width-1:0] prompt_trail [num_chan];
   int                    last_chan;

   ca_channel_top #(.num_chan(num_chan), .hist_width(hist_width)) uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_we    (cfg_we),
      .cfg_chan  (cfg_chan),
      .cfg_prn   (cfg_prn),
      .cfg_dphi  (cfg_dphi),
      .smp_valid (smp_valid),
      .smp_chan  (smp_chan),
      .early     (early),
      .prompt    (prompt),
      .late      (late),
      .chip_stb  (chip_stb),
      .epoch     (epoch)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic abort_run();
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic report_mismatch(input string what);
      $display("CHECK FAILED at time %0t: %s", $time, what);
      abort_run();
   endtask

   // Host write seen, the channel starts over from chip 0
   task automatic restart_channel(input int c);
      cfg_seen[c]     = 1'b1;
      host_hit[c]     = 1'b1;
      chan_dphi[c]    = cfg_dphi;
      step_cnt[c]     = 0;
      stb_cnt[c]      = 0;
      stb64_cnt[c]    = 0;
      early_hist[c]   = '0;
      prompt_trail[c] = '0;
   endtask

   // Round robin, a channel may only be passed over after a host write to it
   task automatic check_order(input int c);
      int nxt;
      int n;
      nxt = (last_chan + 1) % num_chan;
      n   = 0;
      while (nxt != c && n < num_chan) begin
         assert (host_hit[nxt])
         else report_mismatch($sformatf("slot of channel %0d skipped, got %0d", nxt, c));
         nxt = (nxt + 1) % num_chan;
         n++;
      end
      last_chan = c;
      for (int i = 0; i < num_chan; i++) begin
         host_hit[i] = 1'b0;
      end
   endtask

   task automatic check_step(input int c);
      int   k;
      int   idx;
      int   exp_cnt;
      logic exp_prompt;
      logic exp_late;
      step_cnt[c]++;
      k          = step_cnt[c];
      exp_prompt = early_hist[c][hist_width-1];
      exp_late   = prompt_trail[c][hist_width-1];
      assert (prompt === exp_prompt && late === exp_late)
      else report_mismatch($sformatf("ch %0d step %0d prompt/late %b%b", c, k, prompt, late));
      early_hist[c]   = {early_hist[c][hist_width-2:0], early};
      prompt_trail[c] = {prompt_trail[c][hist_width-2:0], exp_prompt};
      // Zero offset gives one chip per four steps
      if (chan_dphi[c] == 16'sd0) begin
         assert (chip_stb === (k % 4 == 0))
         else report_mismatch($sformatf("ch %0d step %0d chip_stb %b", c, k, chip_stb));
      end else if (k <= 64) begin
         if (chip_stb) stb64_cnt[c]++;
         // Accumulator wraps over 64 steps
         exp_cnt = (64 * (16384 + int'(chan_dphi[c]))) / 65536;
         assert (k < 64 || stb64_cnt[c] == exp_cnt)
         else report_mismatch($sformatf("ch %0d strobes %0d, want %0d", c, stb64_cnt[c],
                                        exp_cnt));
      end
      if (chip_stb) begin
         stb_cnt[c]++;
         idx = (stb_cnt[c] - 1) % code_len;
         // First ten chips of every epoch
         if (idx < 10) begin
            assert (early === chan_word[c][9-idx])
            else report_mismatch($sformatf("ch %0d chip %0d early %b", c, idx, early));
         end
      end
      assert (epoch === (chip_stb && stb_cnt[c] % code_len == 0))
      else report_mismatch($sformatf("ch %0d epoch %b at strobe %0d", c, epoch, stb_cnt[c]));
   endtask

   // Sample at the falling edge where all outputs are settled
   always @(negedge clk) begin
      if (rst_n) begin
         if (cfg_we) restart_channel(int'(cfg_chan));
         if (smp_valid) begin
            check_order(int'(smp_chan));
            if (cfg_seen[smp_chan]) check_step(int'(smp_chan));
         end
      end
   end

   task automatic drive_cycle(input int cyc);
      cfg_we = 1'b0;
      for (int r = 0; r < n_cfg; r++) begin
         if (cfg_cycle[r] == cyc) begin
            cfg_we   = 1'b1;
            cfg_chan = cfg_chan_tab[r];
            cfg_prn  = cfg_prn_tab[r];
            cfg_dphi = cfg_dphi_tab[r];
         end
      end
      // Random rewrites of channel 3 once setup is done
      if (!cfg_we && cyc > rewrite_from) begin
         lcg_state = lcg_next(lcg_state);
         if (lcg_state[31:28] == 4'h0) begin
            cfg_we   = 1'b1;
            cfg_chan = 2'd3;
            cfg_prn  = chan_prn[3];
            cfg_dphi = cfg_dphi_tab[3];
         end
      end
   endtask

   initial begin
      int   cyc;
      logic done;
      rst_n     = 1'b0;
      cfg_we    = 1'b0;
      cfg_chan  = '0;
      cfg_prn   = '0;
      cfg_dphi  = '0;
      lcg_state = 32'h33b4a4a9;
      last_chan = num_chan - 1;
      n_cfg     = 0;
      for (int i = 0; i < num_chan; i++) begin
         cfg_seen[i] = 1'b0;
         host_hit[i] = 1'b0;
         stb_cnt[i]  = 0;
         chan_word[i] = '0;
         chan_prn[i]  = '0;
      end
      for (int i = 0; i < stim_words; i++) begin
         stim[i] = '0;
      end
      $readmemh("ca_stim.txt", stim);
      // Records of five words, kind 0 ends the list
      for (int r = 0; r < stim_words / 5 && stim[5*r] != 32'd0; r++) begin
         if (stim[5*r] == 32'd1 && n_cfg < max_cfg) begin
            cfg_chan_tab[n_cfg] = chan_t'(stim[5*r+1]);
            cfg_prn_tab[n_cfg]  = prn_t'(stim[5*r+2]);
            cfg_dphi_tab[n_cfg] = dphi_t'(stim[5*r+3]);
            cfg_cycle[n_cfg]    = int'(stim[5*r+4]);
            chan_prn[cfg_chan_tab[n_cfg]] = cfg_prn_tab[n_cfg];
            n_cfg++;
         end else if (stim[5*r] == 32'd2) begin
            chan_word[chan_t'(stim[5*r+1])] = stim[5*r+2][9:0];
         end
      end
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;
      cyc  = 0;
      done = 1'b0;
      // Run until channels 0 to 2 are past one epoch and ten more chips
      while (!done && cyc < max_cycles) begin
         @(posedge clk);
         #1;
         drive_cycle(cyc);
         cyc++;
         done = 1'b1;
         for (int c = 0; c < 3; c++) begin
            if (stb_cnt[c] < run_chips) done = 1'b0;
         end
      end
      if (!done) begin
         $display("Timeout: channels did not finish their chip runs in %0d cycles", cyc);
         abort_run();
      end else if (uut.u_chk.fail_cnt == 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         $display("Bound assertions failed %0d times", uut.u_chk.fail_cnt);
         abort_run();
      end
   end

endmodule

`default_nettype wire

//--- ca_stim.txt
// kind chan prn dphi cycle  kind 1 configures a channel, cycle counted after reset
// kind chan word 0 0        kind 2 is the first ten chips (ICD octal), kind 0 ends
1 0 01 0000 02
1 1 07 0000 05
1 2 13 03e8 09
1 3 1f 0000 0e
2 0 320 0 0
2 1 259 0 0
2 2 39b 0 0
2 3 395 0 0
0 0 0 0 0

//--- project.f
gps_types_pkg.sv
ca_code_pkg.sv
ca_generator_sw.sv
ca_upsampler_sw.sv
state_ram.sv
state_arbiter.sv
channel_sequencer.sv
ca_channel_top.sv
ca_channel_asserts.sv
ca_channel_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = ca_channel_tb
FLIST = project.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
